// ==== chip8_pkg.sv ====
package chip8_pkg;

    // Datapath widths
    localparam int ADDR_W    = 12;
    localparam int BYTE_W    = 8;
    localparam int INSTR_W   = 16;
    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 16;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Program start and the flag register
    localparam addr_t    RESET_PC = 12'h200;
    localparam reg_idx_t VF_IDX   = 4'd15;

    // Queue payload, instruction word plus the address it came from
    typedef struct packed {
        instr_t instr;
        addr_t  pc;
    } fetch_item_t;

    // Sub-operation of the 8xyN group, encoded as the low nibble
    typedef enum logic [3:0] {
        ALU_LD   = 4'h0,
        ALU_OR   = 4'h1,
        ALU_AND  = 4'h2,
        ALU_XOR  = 4'h3,
        ALU_ADD  = 4'h4,
        ALU_SUB  = 4'h5,
        ALU_SHR  = 4'h6,
        ALU_SUBN = 4'h7,
        ALU_SHL  = 4'h8
    } alu_op_e;

    // Instruction classes kept by the core, everything else is a no-op
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LD_BYTE,
        OP_ADD_BYTE,
        OP_ALU,
        OP_SE_BYTE,
        OP_SNE_BYTE,
        OP_SE_REG,
        OP_SNE_REG,
        OP_JP,
        OP_JP_V0
    } op_class_e;

    // Instruction field helpers
    function automatic logic [3:0] instr_opc(instr_t instr);
        return instr[15:12];
    endfunction

    function automatic reg_idx_t instr_x(instr_t instr);
        return instr[11:8];
    endfunction

    function automatic reg_idx_t instr_y(instr_t instr);
        return instr[7:4];
    endfunction

    function automatic byte_t instr_kk(instr_t instr);
        return instr[7:0];
    endfunction

    function automatic addr_t instr_nnn(instr_t instr);
        return instr[11:0];
    endfunction

endpackage

// ==== chip8_instr_if.sv ====
interface chip8_instr_if;

    logic                   valid;
    logic                   ready;
    chip8_pkg::fetch_item_t item;
    // Drop request travelling upstream from execute
    logic                   flush;

    modport producer (
        output valid,
        output item,
        input  ready,
        input  flush
    );

    modport consumer (
        input  valid,
        input  item,
        output ready,
        output flush
    );

endinterface

// ==== chip8_fetch.sv ====
module chip8_fetch #(
    parameter chip8_pkg::addr_t START_PC = chip8_pkg::RESET_PC
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                redirect_i,
    input  chip8_pkg::addr_t    target_i,
    output logic                mem_rd_o,
    output chip8_pkg::addr_t    mem_addr_o,
    input  chip8_pkg::byte_t    mem_rdata_i,
    input  logic                mem_ack_i,
    chip8_instr_if.producer     q
);

    typedef enum logic [1:0] {
        S_HI,
        S_LO,
        S_OFFER,
        S_DISCARD
    } state_e;

    state_e           state_q;
    chip8_pkg::addr_t pc_q;
    chip8_pkg::byte_t hi_q;
    chip8_pkg::byte_t lo_q;
    logic             xfer;

    assign q.valid = (state_q == S_OFFER);
    assign q.item  = chip8_pkg::fetch_item_t'{instr: {hi_q, lo_q}, pc: pc_q};
    assign xfer    = q.valid && q.ready;

    // Fetch pointer follows a redirect or steps per accepted instruction
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= START_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (xfer) begin
            pc_q <= pc_q + 12'd2;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_HI;
            mem_rd_o   <= 1'b0;
            mem_addr_o <= START_PC;
        end else begin
            case (state_q)
                S_HI, S_LO: begin
                    if (mem_rd_o && !mem_ack_i) begin
                        // A redirect during a pending read throws its byte away
                        if (redirect_i) begin
                            state_q <= S_DISCARD;
                        end
                    end else if (mem_rd_o) begin
                        mem_rd_o <= 1'b0;
                        if (redirect_i) begin
                            state_q <= S_HI;
                        end else if (state_q == S_HI) begin
                            state_q <= S_LO;
                        end else begin
                            state_q <= S_OFFER;
                        end
                    end else if (redirect_i) begin
                        state_q <= S_HI;
                    end else begin
                        mem_rd_o   <= 1'b1;
                        mem_addr_o <= (state_q == S_HI) ? pc_q : pc_q + 12'd1;
                    end
                end
                S_OFFER: begin
                    // Offered item is dropped on flush
                    if (q.flush || xfer) begin
                        state_q <= S_HI;
                    end
                end
                S_DISCARD: begin
                    if (mem_ack_i) begin
                        mem_rd_o <= 1'b0;
                        state_q  <= S_HI;
                    end
                end
                default: begin
                    state_q <= S_HI;
                end
            endcase
        end
    end

    // Acknowledged byte lands in the half that was requested
    always_ff @(posedge clk) begin
        if (mem_rd_o && mem_ack_i && !redirect_i) begin
            if (state_q == S_HI) begin
                hi_q <= mem_rdata_i;
            end
            if (state_q == S_LO) begin
                lo_q <= mem_rdata_i;
            end
        end
    end

endmodule

// ==== chip8_instr_fifo.sv ====
module chip8_instr_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n_i,
    chip8_instr_if.consumer in_q,
    chip8_instr_if.producer out_q,
    input  logic            flush_i
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    chip8_pkg::fetch_item_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == CNT_W'(FIFO_DEPTH));

    // Nothing enters on the redirect cycle
    assign in_q.ready = !full && !flush_i;
    // Pass the drop request on to fetch
    assign in_q.flush = out_q.flush;

    assign out_q.valid = (count_q != '0);
    assign out_q.item  = mem[rd_ptr_q];

    assign push = in_q.valid && in_q.ready;
    assign pop  = out_q.valid && out_q.ready;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Flush empties the queue in one step
            rd_ptr_q <= wr_ptr_q;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_q.item;
        end
    end

endmodule

// ==== chip8_exec.sv ====
module chip8_exec #(
    parameter chip8_pkg::addr_t START_PC = chip8_pkg::RESET_PC
) (
    input  logic                clk,
    input  logic                arst_n_i,
    chip8_instr_if.consumer     q,
    output logic                redirect_o,
    output chip8_pkg::addr_t    target_o,
    output logic                ret_valid_o,
    output chip8_pkg::addr_t    ret_pc_o,
    output logic                ret_rd_we_o,
    output chip8_pkg::reg_idx_t ret_rd_idx_o,
    output chip8_pkg::byte_t    ret_rd_data_o,
    output logic                ret_vf_we_o,
    output logic                ret_vf_o
);

    chip8_pkg::byte_t       regs [chip8_pkg::NUM_REGS];
    logic                   stage_valid_q;
    chip8_pkg::fetch_item_t stage_q;
    chip8_pkg::addr_t       exp_pc_q;

    chip8_pkg::instr_t      instr;
    chip8_pkg::addr_t       pc;
    chip8_pkg::reg_idx_t    x;
    chip8_pkg::byte_t       kk;
    chip8_pkg::addr_t       nnn;
    chip8_pkg::byte_t       vx;
    chip8_pkg::byte_t       vy;
    chip8_pkg::byte_t       v0;

    chip8_pkg::op_class_e   op_class;
    chip8_pkg::alu_op_e     alu_op;
    chip8_pkg::byte_t       alu_res;
    logic                   alu_flag;
    logic                   alu_flag_we;
    logic [8:0]             sum;

    logic                   retire;
    logic                   rd_we;
    chip8_pkg::byte_t       rd_data;
    logic                   vf_we;
    logic                   vf_val;
    logic                   taken;

    assign instr = stage_q.instr;
    assign pc    = stage_q.pc;
    assign x     = chip8_pkg::instr_x(instr);
    assign kk    = chip8_pkg::instr_kk(instr);
    assign nnn   = chip8_pkg::instr_nnn(instr);
    assign vx    = regs[x];
    assign vy    = regs[chip8_pkg::instr_y(instr)];
    assign v0    = regs[0];

    // Hold off on the redirect cycle so nothing from the old path slips in
    assign q.ready = !redirect_o;
    assign q.flush = redirect_o;

    // Items left over from a flushed path carry the wrong pc
    assign retire = stage_valid_q && (pc == exp_pc_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_valid_q <= 1'b0;
        end else begin
            stage_valid_q <= q.valid && q.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (q.valid && q.ready) begin
            stage_q <= q.item;
        end
    end

    // Decode
    always_comb begin
        op_class = chip8_pkg::OP_NOP;
        alu_op   = chip8_pkg::ALU_LD;
        case (chip8_pkg::instr_opc(instr))
            4'h1: op_class = chip8_pkg::OP_JP;
            4'h3: op_class = chip8_pkg::OP_SE_BYTE;
            4'h4: op_class = chip8_pkg::OP_SNE_BYTE;
            4'h5: if (instr[3:0] == 4'h0) op_class = chip8_pkg::OP_SE_REG;
            4'h6: op_class = chip8_pkg::OP_LD_BYTE;
            4'h7: op_class = chip8_pkg::OP_ADD_BYTE;
            4'h8: begin
                if (instr[3:0] <= 4'h8) begin
                    op_class = chip8_pkg::OP_ALU;
                    alu_op   = chip8_pkg::alu_op_e'(instr[3:0]);
                end
            end
            4'h9: if (instr[3:0] == 4'h0) op_class = chip8_pkg::OP_SNE_REG;
            4'hB: op_class = chip8_pkg::OP_JP_V0;
            default: op_class = chip8_pkg::OP_NOP;
        endcase
    end

    // 8xy group
    always_comb begin
        sum         = {1'b0, vx} + {1'b0, vy};
        alu_res     = vy;
        alu_flag    = 1'b0;
        alu_flag_we = 1'b0;
        case (alu_op)
            chip8_pkg::ALU_OR:  alu_res = vx | vy;
            chip8_pkg::ALU_AND: alu_res = vx & vy;
            chip8_pkg::ALU_XOR: alu_res = vx ^ vy;
            chip8_pkg::ALU_ADD: begin
                alu_res     = sum[7:0];
                alu_flag    = sum[8];
                alu_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SUB: begin
                alu_res     = vx - vy;
                alu_flag    = (vx > vy);
                alu_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SHR: begin
                alu_res     = vx >> 1;
                alu_flag    = vx[0];
                alu_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SUBN: begin
                alu_res     = vy - vx;
                alu_flag    = (vy > vx);
                alu_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SHL: begin
                alu_res     = vx << 1;
                alu_flag    = vx[7];
                alu_flag_we = 1'b1;
            end
            default: alu_res = vy;
        endcase
    end

    // Writeback values, skips and jumps
    always_comb begin
        rd_we    = 1'b0;
        rd_data  = kk;
        vf_we    = 1'b0;
        vf_val   = 1'b0;
        taken    = 1'b0;
        target_o = pc + 12'd4;
        case (op_class)
            chip8_pkg::OP_LD_BYTE:  rd_we = 1'b1;
            chip8_pkg::OP_ADD_BYTE: begin
                rd_we   = 1'b1;
                rd_data = vx + kk;
            end
            chip8_pkg::OP_ALU: begin
                rd_we   = 1'b1;
                rd_data = alu_res;
                vf_we   = alu_flag_we;
                vf_val  = alu_flag;
            end
            chip8_pkg::OP_SE_BYTE:  taken = (vx == kk);
            chip8_pkg::OP_SNE_BYTE: taken = (vx != kk);
            chip8_pkg::OP_SE_REG:   taken = (vx == vy);
            chip8_pkg::OP_SNE_REG:  taken = (vx != vy);
            chip8_pkg::OP_JP: begin
                taken    = 1'b1;
                target_o = nnn;
            end
            chip8_pkg::OP_JP_V0: begin
                taken    = 1'b1;
                target_o = nnn + chip8_pkg::addr_t'(v0);
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = retire && taken;
    assign ret_valid_o   = retire;
    assign ret_pc_o      = pc;
    assign ret_rd_we_o   = retire && rd_we;
    assign ret_rd_idx_o  = x;
    assign ret_rd_data_o = rd_data;
    assign ret_vf_we_o   = retire && vf_we;
    assign ret_vf_o      = vf_val;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_pc_q <= START_PC;
        end else if (retire) begin
            exp_pc_q <= taken ? target_o : pc + 12'd2;
        end
    end

    // Flag first, so a result aimed at VF wins
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < chip8_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire) begin
            if (vf_we) begin
                regs[chip8_pkg::VF_IDX] <= {7'd0, vf_val};
            end
            if (rd_we) begin
                regs[x] <= rd_data;
            end
        end
    end

endmodule

// ==== chip8_core.sv ====
module chip8_core #(
    parameter int               FIFO_DEPTH = 4,
    parameter chip8_pkg::addr_t START_PC   = chip8_pkg::RESET_PC
) (
    input  logic                clk,
    input  logic                arst_n_i,
    output logic                mem_rd_o,
    output chip8_pkg::addr_t    mem_addr_o,
    input  chip8_pkg::byte_t    mem_rdata_i,
    input  logic                mem_ack_i,
    output logic                ret_valid_o,
    output chip8_pkg::addr_t    ret_pc_o,
    output logic                ret_rd_we_o,
    output chip8_pkg::reg_idx_t ret_rd_idx_o,
    output chip8_pkg::byte_t    ret_rd_data_o,
    output logic                ret_vf_we_o,
    output logic                ret_vf_o
);

    logic             redirect;
    chip8_pkg::addr_t target;

    chip8_instr_if fetch_q ();
    chip8_instr_if exec_q ();

    chip8_fetch #(
        .START_PC (START_PC)
    ) u_fetch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .redirect_i  (redirect),
        .target_i    (target),
        .mem_rd_o    (mem_rd_o),
        .mem_addr_o  (mem_addr_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ack_i   (mem_ack_i),
        .q           (fetch_q.producer)
    );

    chip8_instr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .in_q     (fetch_q.consumer),
        .out_q    (exec_q.producer),
        .flush_i  (redirect)
    );

    chip8_exec #(
        .START_PC (START_PC)
    ) u_exec (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .q             (exec_q.consumer),
        .redirect_o    (redirect),
        .target_o      (target),
        .ret_valid_o   (ret_valid_o),
        .ret_pc_o      (ret_pc_o),
        .ret_rd_we_o   (ret_rd_we_o),
        .ret_rd_idx_o  (ret_rd_idx_o),
        .ret_rd_data_o (ret_rd_data_o),
        .ret_vf_we_o   (ret_vf_we_o),
        .ret_vf_o      (ret_vf_o)
    );

endmodule

// ==== chip8_core_chk.sv ====
module chip8_core_chk (
    input logic              clk,
    input logic              arst_n_i,
    input logic              mem_rd_i,
    input chip8_pkg::addr_t  mem_addr_i,
    input logic              mem_ack_i,
    input logic              take_valid_i,
    input logic              take_ready_i,
    input chip8_pkg::instr_t instr_i,
    input logic              ret_valid_i,
    input logic              ret_vf_we_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    // A pending read keeps its request and address until acknowledged
    mem_req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_rd_i && !mem_ack_i |=> mem_rd_i && $stable(mem_addr_i))
        else begin
            fail_cnt++;
            $error("Memory request dropped or address moved before the acknowledge");
        end

    // Execute retires one cycle after taking an item
    retire_after_take: assert property (@(posedge clk) disable iff (!arst_n_i)
        ret_valid_i |-> $past(take_valid_i && take_ready_i))
        else begin
            fail_cnt++;
            $error("Retire without an item taken on the previous cycle");
        end

    vf_only_from_alu: assert property (@(posedge clk) disable iff (!arst_n_i)
        ret_vf_we_i |-> ret_valid_i && (instr_i[15:12] == 4'h8))
        else begin
            fail_cnt++;
            $error("Flag write reported for an instruction outside the 8xy group");
        end

endmodule

// ==== tb_chip8_core.sv ====
module tb_chip8_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int               CLK_PERIOD   = 100;
    localparam int               RESET_CYCLES = 4;
    localparam int               N_ENTRIES    = 38;
    localparam chip8_pkg::addr_t START_PC     = chip8_pkg::RESET_PC;
    localparam int               TIMEOUT_NS   = (N_ENTRIES * 4 * 6 + RESET_CYCLES) * CLK_PERIOD;

    // One program word plus a flag saying whether execution reaches it
    typedef struct packed {
        logic              on_path;
        chip8_pkg::instr_t instr;
    } prog_entry_t;

    typedef struct {
        chip8_pkg::addr_t    pc;
        logic                rd_we;
        chip8_pkg::reg_idx_t rd_idx;
        chip8_pkg::byte_t    rd_data;
        logic                vf_we;
        logic                vf;
    } retire_t;

    // Loads and byte adds, then the 8xy group on V3 and VF
    // Skips with off-path words in the skipped slots, then both jumps and a halt loop
    localparam prog_entry_t PROG [N_ENTRIES] = '{
        17'h1_6F05, 17'h1_6AF0, 17'h1_7A20, 17'h1_6135,
        17'h1_62C3, 17'h1_8310, 17'h1_8321, 17'h1_8312,
        17'h1_8323, 17'h1_8324, 17'h1_8315, 17'h1_8317,
        17'h1_8306, 17'h1_8308, 17'h1_8F24, 17'h1_8F16,
        17'h1_3135, 17'h0_6E11, 17'h1_4135, 17'h1_5120,
        17'h1_9120, 17'h0_6E22, 17'h1_3136, 17'h1_4136,
        17'h0_6E33, 17'h1_6435, 17'h1_5140, 17'h0_6E44,
        17'h1_9140, 17'h1_1240, 17'h0_6E55, 17'h0_6E66,
        17'h1_6006, 17'h1_B244, 17'h0_6E77, 17'h0_6E88,
        17'h0_6E99, 17'h1_124A
    };

    logic                clk;
    logic                arst_n_i;
    logic                mem_rd_o;
    chip8_pkg::addr_t    mem_addr_o;
    chip8_pkg::byte_t    mem_rdata_i;
    logic                mem_ack_i;
    logic                ret_valid_o;
    chip8_pkg::addr_t    ret_pc_o;
    logic                ret_rd_we_o;
    chip8_pkg::reg_idx_t ret_rd_idx_o;
    chip8_pkg::byte_t    ret_rd_data_o;
    logic                ret_vf_we_o;
    logic                ret_vf_o;

    chip8_pkg::byte_t mem [4096];
    retire_t          exp_q [$];
    integer           seed = 32'hbcec_59a2;
    int               errors;
    int               retired;

    chip8_core dut (.*);

    bind chip8_core chip8_core_chk u_chk (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mem_rd_i     (mem_rd_o),
        .mem_addr_i   (mem_addr_o),
        .mem_ack_i    (mem_ack_i),
        .take_valid_i (exec_q.valid),
        .take_ready_i (exec_q.ready),
        .instr_i      (u_exec.instr),
        .ret_valid_i  (ret_valid_o),
        .ret_vf_we_i  (ret_vf_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_pc(chip8_pkg::addr_t got, chip8_pkg::addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: retired pc %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(chip8_pkg::reg_idx_t got_idx, chip8_pkg::byte_t got_data,
                             chip8_pkg::reg_idx_t exp_idx, chip8_pkg::byte_t exp_data);
        if (got_idx !== exp_idx || got_data !== exp_data) begin
            $display("MISMATCH at %0t: V%h <= %h, expected V%h <= %h",
                     $time, got_idx, got_data, exp_idx, exp_data);
            errors++;
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic print_counts();
        $display("Retires checked %0d of %0d, value errors %0d, assertion failures %0d",
                 retired, exp_q.size(), errors, dut.u_chk.fail_cnt);
    endtask

    task automatic load_memory();
        for (int a = 0; a < 4096; a++) begin
            mem[a] = chip8_pkg::byte_t'(a ^ (a >> 4) ^ (a >> 8));
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            mem[START_PC + 2 * i]     = PROG[i].instr[15:8];
            mem[START_PC + 2 * i + 1] = PROG[i].instr[7:0];
        end
    endtask

    // Runs the program by the instruction rules until the halt loop
    task automatic build_model();
        chip8_pkg::byte_t    v [16];
        chip8_pkg::addr_t    pc;
        chip8_pkg::addr_t    next;
        chip8_pkg::instr_t   ins;
        chip8_pkg::reg_idx_t x;
        chip8_pkg::reg_idx_t y;
        chip8_pkg::byte_t    kk;
        logic [8:0]          wide;
        retire_t             e;
        int                  idx;
        int                  on_count;
        logic                done;
        for (int i = 0; i < 16; i++) begin
            v[i] = '0;
        end
        pc = START_PC;
        done = 1'b0;
        while (!done) begin
            idx = int'(chip8_pkg::addr_t'(pc - START_PC)) / 2;
            if (idx >= N_ENTRIES) begin
                $display("Program table error: execution leaves the table at pc %h", pc);
                errors++;
                break;
            end
            ins = PROG[idx].instr;
            if (!PROG[idx].on_path) begin
                $display("Program table error: entry at pc %h is reached but marked off", pc);
                errors++;
            end
            x = ins[11:8];
            y = ins[7:4];
            kk = ins[7:0];
            next = pc + 12'd2;
            e.pc = pc;
            e.rd_we = 1'b0;
            e.rd_idx = x;
            e.rd_data = '0;
            e.vf_we = 1'b0;
            e.vf = 1'b0;
            case (ins[15:12])
                4'h1: begin
                    next = ins[11:0];
                    done = (ins[11:0] == pc);
                end
                4'h3: if (v[x] == kk) next = pc + 12'd4;
                4'h4: if (v[x] != kk) next = pc + 12'd4;
                4'h5: if (ins[3:0] == 4'h0 && v[x] == v[y]) next = pc + 12'd4;
                4'h9: if (ins[3:0] == 4'h0 && v[x] != v[y]) next = pc + 12'd4;
                4'h6: begin
                    e.rd_we = 1'b1;
                    e.rd_data = kk;
                end
                4'h7: begin
                    e.rd_we = 1'b1;
                    e.rd_data = v[x] + kk;
                end
                4'h8: begin
                    e.rd_we = (ins[3:0] <= 4'h8);
                    e.vf_we = (ins[3:0] >= 4'h4) && (ins[3:0] <= 4'h8);
                    wide = {1'b0, v[x]} + {1'b0, v[y]};
                    case (ins[3:0])
                        4'h0: e.rd_data = v[y];
                        4'h1: e.rd_data = v[x] | v[y];
                        4'h2: e.rd_data = v[x] & v[y];
                        4'h3: e.rd_data = v[x] ^ v[y];
                        4'h4: {e.vf, e.rd_data} = wide;
                        4'h5: {e.vf, e.rd_data} = {v[x] > v[y], v[x] - v[y]};
                        4'h6: {e.vf, e.rd_data} = {v[x][0], v[x] >> 1};
                        4'h7: {e.vf, e.rd_data} = {v[y] > v[x], v[y] - v[x]};
                        4'h8: {e.vf, e.rd_data} = {v[x][7], v[x] << 1};
                        default: e.rd_data = '0;
                    endcase
                end
                4'hB: next = ins[11:0] + chip8_pkg::addr_t'(v[0]);
                default: next = pc + 12'd2;
            endcase
            // Flag lands first so that a result aimed at VF overwrites it
            if (e.vf_we) v[15] = {7'd0, e.vf};
            if (e.rd_we) v[x] = e.rd_data;
            exp_q.push_back(e);
            pc = next;
        end
        on_count = 0;
        foreach (PROG[i]) on_count += PROG[i].on_path;
        if (on_count != exp_q.size()) begin
            $display("Program table error: %0d entries marked on the path, %0d executed",
                     on_count, exp_q.size());
            errors++;
        end
    endtask

    // Memory answers each read after 1 to 4 cycles
    initial begin
        int lat;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk);
            #10;
            mem_ack_i = 1'b0;
            if (mem_rd_o === 1'b1) begin
                lat = 1 + ($unsigned($random(seed)) % 4);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #10;
                end
                mem_ack_i = 1'b1;
                mem_rdata_i = mem[mem_addr_o];
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: only %0d of %0d expected retires seen before the watchdog fired",
                 retired, exp_q.size());
        print_counts();
        $display("TB FAILED");
        $finish;
    end

    initial begin
        arst_n_i = 1'b0;
        errors = 0;
        retired = 0;
        load_memory();
        build_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        arst_n_i = 1'b1;
        foreach (exp_q[i]) begin
            do @(negedge clk); while (ret_valid_o !== 1'b1);
            check_pc(ret_pc_o, exp_q[i].pc);
            check_flag("Vx write enable", ret_rd_we_o, exp_q[i].rd_we);
            if (exp_q[i].rd_we) begin
                check_reg(ret_rd_idx_o, ret_rd_data_o, exp_q[i].rd_idx, exp_q[i].rd_data);
            end
            check_flag("VF write enable", ret_vf_we_o, exp_q[i].vf_we);
            if (exp_q[i].vf_we) begin
                check_flag("VF value", ret_vf_o, exp_q[i].vf);
            end
            retired++;
        end
        print_counts();
        if (errors == 0 && dut.u_chk.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== chip8.f ====
chip8_pkg.sv
chip8_instr_if.sv
chip8_fetch.sv
chip8_instr_fifo.sv
chip8_exec.sv
chip8_core.sv
chip8_core_chk.sv
tb_chip8_core.sv

// ==== Bender.yml ====
package:
  name: chip8

sources:
  - chip8_pkg.sv
  - chip8_instr_if.sv
  - chip8_fetch.sv
  - chip8_instr_fifo.sv
  - chip8_exec.sv
  - chip8_core.sv
  - target: test
    files:
      - chip8_core_chk.sv
      - tb_chip8_core.sv
